// File: usb_packet_pkg.sv
package usb_packet_pkg;

    typedef logic [3:0]  bag_type_t;
    typedef logic [3:0]  dev_idx_t;
    typedef logic [3:0]  data_idx_t;
    typedef logic [15:0] conf_cmd_t;
    typedef logic [31:0] pkt_word_t;
    typedef logic [31:0] cfg_word_t;
    typedef logic [7:0]  pkt_byte_t;

    localparam bag_type_t BAG_INIT   = 4'h0;
    localparam bag_type_t BAG_ACK    = 4'h1;
    localparam bag_type_t BAG_NAK    = 4'h2;
    localparam bag_type_t BAG_STL    = 4'h3;
    localparam bag_type_t BAG_DIDX   = 4'h5;
    localparam bag_type_t BAG_DPARAM = 4'h6;
    localparam bag_type_t BAG_DDIDX  = 4'h7;
    localparam bag_type_t BAG_DLINK  = 4'h8;
    localparam bag_type_t BAG_DTYPE  = 4'h9;
    localparam bag_type_t BAG_DTEMP  = 4'hA;
    localparam bag_type_t BAG_DATA0  = 4'hD;
    localparam bag_type_t BAG_DATA1  = 4'hE;
    localparam bag_type_t BAG_ERROR  = 4'hF;

    localparam int PKT_BYTES = 5;

endpackage

// File: bridge_regs_pkg.sv
package bridge_regs_pkg;

    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    localparam apb_addr_t REG_CTRL   = 8'h00;
    localparam apb_addr_t REG_CFG    = 8'h04;
    localparam apb_addr_t REG_CONF   = 8'h08;
    localparam apb_addr_t REG_STATUS = 8'h0C;
    localparam apb_addr_t REG_RDATA  = 8'h10;

    // Bit positions inside STATUS
    localparam int STAT_READY    = 0;
    localparam int STAT_BUSY     = 1;
    localparam int STAT_PEND     = 2;
    localparam int STAT_TYPE_LSB = 8;
    localparam int STAT_DROP_LSB = 16;

endpackage

// File: bag_if.sv
interface bag_if;
    import usb_packet_pkg::*;

    logic      start;
    logic      done;
    bag_type_t btype;
    pkt_word_t data;

    // Four-phase handshake with btype and data held while start is high
    modport initiator (
        output start,
        output btype,
        output data,
        input  done
    );

    modport target (
        input  start,
        input  btype,
        input  data,
        output done
    );

endinterface

// File: console_regs.sv
module console_regs #(
    parameter int DROP_CNT_W = 8
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  bridge_regs_pkg::apb_addr_t paddr,
    input  bridge_regs_pkg::apb_data_t pwdata,
    output bridge_regs_pkg::apb_data_t prdata,
    output logic                       pslverr,
    bag_if.initiator                   cs_send,
    bag_if.target                      cs_read,
    input  logic                       dev_ready,
    input  logic                       drop
);
    import bridge_regs_pkg::*;
    import usb_packet_pkg::*;

    dev_idx_t              dev_idx;
    data_idx_t             data_idx;
    conf_cmd_t             conf;
    bag_type_t             send_type;
    logic                  send_start;
    logic                  send_busy;
    bag_type_t             rd_type;
    pkt_word_t             rd_word;
    logic                  rd_pending;
    logic                  rd_done;
    logic [DROP_CNT_W-1:0] drop_cnt;
    logic                  access;
    logic                  wr_en;
    logic                  rd_en;
    logic                  addr_ok;
    apb_data_t             status;
    apb_data_t             rdata;

    assign access    = psel & penable;
    assign wr_en     = access & pwrite;
    assign rd_en     = access & ~pwrite;
    assign send_busy = send_start | cs_send.done;

    assign cs_send.start = send_start;
    assign cs_send.btype = send_type;
    assign cs_send.data  = cfg_word_t'({dev_idx, data_idx, conf, 8'h00});
    assign cs_read.done  = rd_done;

    always_comb begin
        status = '0;
        status[STAT_READY] = dev_ready;
        status[STAT_BUSY] = send_busy;
        status[STAT_PEND] = rd_pending;
        status[STAT_TYPE_LSB +: 4] = rd_type;
        status[STAT_DROP_LSB +: DROP_CNT_W] = drop_cnt;
        addr_ok = 1'b1;
        rdata = '0;
        case (paddr)
            REG_CTRL:   rdata[3:0] = send_type;
            REG_CFG:    rdata[7:0] = {data_idx, dev_idx};
            REG_CONF:   rdata[15:0] = conf;
            REG_STATUS: rdata = status;
            REG_RDATA:  rdata = rd_word;
            default:    addr_ok = 1'b0;
        endcase
    end

    assign prdata  = rdata;
    assign pslverr = access & (~addr_ok | (pwrite & (paddr == REG_CTRL) & send_busy));

    // A CTRL write while busy is refused and flagged through pslverr
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dev_idx <= '0;
            data_idx <= '0;
            conf <= '0;
            send_type <= BAG_INIT;
            send_start <= 1'b0;
        end else begin
            if (send_start && cs_send.done) begin
                send_start <= 1'b0;
            end
            if (wr_en) begin
                case (paddr)
                    REG_CTRL: begin
                        if (!send_busy) begin
                            send_start <= 1'b1;
                            send_type <= pwdata[3:0];
                        end
                    end
                    REG_CFG: begin
                        dev_idx <= pwdata[3:0];
                        data_idx <= pwdata[7:4];
                    end
                    REG_CONF: conf <= pwdata[15:0];
                    default: ;
                endcase
            end
        end
    end

    // Done stays high until the host has read RDATA so a second packet waits upstream
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_type <= BAG_INIT;
            rd_pending <= 1'b0;
            rd_done <= 1'b0;
            drop_cnt <= '0;
        end else begin
            if (cs_read.start && !rd_done) begin
                rd_type <= cs_read.btype;
                rd_pending <= 1'b1;
                rd_done <= 1'b1;
            end else if (rd_done && !cs_read.start && !rd_pending) begin
                rd_done <= 1'b0;
            end
            if (rd_en && (paddr == REG_RDATA)) begin
                rd_pending <= 1'b0;
            end
            if (drop && (drop_cnt != '1)) begin
                drop_cnt <= drop_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cs_read.start && !rd_done) begin
            rd_word <= cs_read.data;
        end
    end

endmodule

// File: usb_branch.sv
module usb_branch (
    input  logic     clk,
    input  logic     rst,
    bag_if.target    cs_send,
    bag_if.initiator cs_read,
    bag_if.initiator usb_send,
    bag_if.target    usb_read,
    output logic     dev_ready,
    output logic     drop
);
    import usb_packet_pkg::*;

    typedef enum logic [3:0] {
        ST_LINK_WAIT,
        ST_IDX_SEND,
        ST_TYPE_WAIT,
        ST_WAIT,
        ST_CMD,
        ST_SEND,
        ST_ROUTE,
        ST_CS_READ,
        ST_DROP
    } state_t;

    state_t    state;
    state_t    idle_state;
    bag_type_t send_type;
    cfg_word_t send_cfg;
    bag_type_t rd_type;
    pkt_word_t rd_word;
    bag_type_t tx_type;
    pkt_word_t tx_word;
    logic      link_flag;
    logic      type_flag;
    logic      cs_done;
    logic      cr_start;
    logic      us_start;
    logic      ur_done;
    logic      drop_q;
    logic      rd_new;
    logic      cmd_new;

    assign rd_new  = usb_read.start & ~ur_done;
    assign cmd_new = cs_send.start & ~cs_done;

    // Where to go after a drop depends on how far bring-up has got
    assign idle_state = !link_flag ? ST_LINK_WAIT : (!type_flag ? ST_TYPE_WAIT : ST_WAIT);

    assign cs_send.done   = cs_done;
    assign cs_read.start  = cr_start;
    assign cs_read.btype  = rd_type;
    assign cs_read.data   = rd_word;
    assign usb_send.start = us_start;
    assign usb_send.btype = tx_type;
    assign usb_send.data  = tx_word;
    assign usb_read.done  = ur_done;
    assign dev_ready      = link_flag & type_flag;
    assign drop           = drop_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_LINK_WAIT;
            link_flag <= 1'b0;
            type_flag <= 1'b0;
            cs_done <= 1'b0;
            cr_start <= 1'b0;
            us_start <= 1'b0;
            ur_done <= 1'b0;
            drop_q <= 1'b0;
        end else begin
            drop_q <= 1'b0;
            // Both target sides release done once start has gone low
            if (cs_done && !cs_send.start) begin
                cs_done <= 1'b0;
            end
            if (ur_done && !usb_read.start) begin
                ur_done <= 1'b0;
            end
            case (state)
                ST_LINK_WAIT: begin
                    if (rd_new) begin
                        if (usb_read.btype == BAG_DLINK) begin
                            link_flag <= 1'b1;
                            ur_done <= 1'b1;
                            us_start <= 1'b1;
                            state <= ST_IDX_SEND;
                        end else begin
                            state <= ST_DROP;
                        end
                    end
                end
                ST_IDX_SEND: begin
                    if (us_start && usb_send.done) begin
                        us_start <= 1'b0;
                    end else if (!us_start && !usb_send.done) begin
                        state <= ST_TYPE_WAIT;
                    end
                end
                ST_TYPE_WAIT: begin
                    if (rd_new) begin
                        if (usb_read.btype == BAG_DTYPE) begin
                            type_flag <= 1'b1;
                            ur_done <= 1'b1;
                            state <= ST_WAIT;
                        end else begin
                            state <= ST_DROP;
                        end
                    end
                end
                ST_WAIT: begin
                    if (cmd_new) begin
                        state <= ST_CMD;
                    end else if (rd_new) begin
                        state <= ST_ROUTE;
                    end
                end
                ST_CMD: begin
                    if (send_type == BAG_DPARAM || send_type == BAG_DIDX) begin
                        us_start <= 1'b1;
                        state <= ST_SEND;
                    end else begin
                        cs_done <= 1'b1;
                        state <= ST_WAIT;
                    end
                end
                ST_SEND: begin
                    if (us_start && usb_send.done) begin
                        us_start <= 1'b0;
                    end else if (!us_start && !usb_send.done) begin
                        cs_done <= 1'b1;
                        state <= ST_WAIT;
                    end
                end
                ST_ROUTE: begin
                    if (rd_type == BAG_DTEMP || rd_type == BAG_DATA0 || rd_type == BAG_DATA1) begin
                        cr_start <= 1'b1;
                        state <= ST_CS_READ;
                    end else begin
                        state <= ST_DROP;
                    end
                end
                ST_CS_READ: begin
                    if (cr_start && cs_read.done) begin
                        cr_start <= 1'b0;
                    end else if (!cr_start && !cs_read.done) begin
                        ur_done <= 1'b1;
                        state <= ST_WAIT;
                    end
                end
                ST_DROP: begin
                    ur_done <= 1'b1;
                    drop_q <= 1'b1;
                    state <= idle_state;
                end
                default: state <= ST_LINK_WAIT;
            endcase
        end
    end

    // The config word packs device, data index and conf from bit 31 down
    always_ff @(posedge clk) begin
        if (cmd_new) begin
            send_type <= cs_send.btype;
            send_cfg <= cs_send.data;
        end
        if (rd_new) begin
            rd_type <= usb_read.btype;
            rd_word <= usb_read.data;
        end
        if (state == ST_LINK_WAIT) begin
            tx_type <= BAG_DDIDX;
            tx_word <= {cs_send.data[31:28], 28'h0};
        end else if (state == ST_CMD) begin
            tx_type <= send_type;
            if (send_type == BAG_DPARAM) begin
                tx_word <= {send_cfg[31:28], 4'h0, send_cfg[23:8], 8'h00};
            end else begin
                tx_word <= {send_cfg[31:8], 8'h00};
            end
        end
    end

endmodule

// File: usb_pkt_tx.sv
module usb_pkt_tx (
    input  logic                      clk,
    input  logic                      rst,
    bag_if.target                     usb_send,
    output usb_packet_pkg::pkt_byte_t tx_data,
    output logic                      tx_valid,
    input  logic                      tx_ready
);
    import usb_packet_pkg::*;

    localparam int CNT_W = $clog2(PKT_BYTES);
    localparam int SHIFT_W = PKT_BYTES * 8;

    logic [SHIFT_W-1:0] shift_q;
    logic [CNT_W-1:0]   cnt;
    logic               done_q;
    logic               load;
    logic               accept;

    assign load   = usb_send.start & ~done_q & ~tx_valid;
    assign accept = tx_valid & tx_ready;

    assign usb_send.done = done_q;
    assign tx_data = shift_q[SHIFT_W-1 -: 8];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx_valid <= 1'b0;
            cnt <= '0;
            done_q <= 1'b0;
        end else begin
            if (load) begin
                tx_valid <= 1'b1;
                cnt <= '0;
            end else if (accept) begin
                cnt <= cnt + 1'b1;
                if (cnt == CNT_W'(PKT_BYTES - 1)) begin
                    tx_valid <= 1'b0;
                    done_q <= 1'b1;
                end
            end
            if (done_q && !usb_send.start) begin
                done_q <= 1'b0;
            end
        end
    end

    // Type byte goes first with its high nibble zero
    always_ff @(posedge clk) begin
        if (load) begin
            shift_q <= {4'h0, usb_send.btype, usb_send.data};
        end else if (accept) begin
            shift_q <= {shift_q[SHIFT_W-9:0], 8'h00};
        end
    end

endmodule

// File: usb_pkt_rx.sv
module usb_pkt_rx (
    input  logic                      clk,
    input  logic                      rst,
    bag_if.initiator                  usb_read,
    input  usb_packet_pkg::pkt_byte_t rx_data,
    input  logic                      rx_valid,
    output logic                      rx_ready
);
    import usb_packet_pkg::*;

    localparam int CNT_W = $clog2(PKT_BYTES);

    logic [CNT_W-1:0] cnt;
    logic             full_q;
    logic             start_q;
    bag_type_t        type_q;
    pkt_word_t        word_q;
    logic             take;

    // A complete packet holds the stream off until the handshake is over
    assign rx_ready = ~full_q;
    assign take     = rx_valid & rx_ready;

    assign usb_read.start = start_q;
    assign usb_read.btype = type_q;
    assign usb_read.data  = word_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
            full_q <= 1'b0;
            start_q <= 1'b0;
        end else begin
            if (take) begin
                if (cnt == CNT_W'(PKT_BYTES - 1)) begin
                    cnt <= '0;
                    full_q <= 1'b1;
                    start_q <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
            if (start_q && usb_read.done) begin
                start_q <= 1'b0;
            end
            if (full_q && !start_q && !usb_read.done) begin
                full_q <= 1'b0;
            end
        end
    end

    // Payload arrives most significant byte first
    always_ff @(posedge clk) begin
        if (take) begin
            if (cnt == '0) begin
                type_q <= rx_data[3:0];
            end else begin
                word_q <= {word_q[23:0], rx_data};
            end
        end
    end

endmodule

// File: usb_console_bridge.sv
module usb_console_bridge #(
    parameter int DROP_CNT_W = 8
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  bridge_regs_pkg::apb_addr_t paddr,
    input  bridge_regs_pkg::apb_data_t pwdata,
    output bridge_regs_pkg::apb_data_t prdata,
    output logic                       pslverr,
    output usb_packet_pkg::pkt_byte_t  tx_data,
    output logic                       tx_valid,
    input  logic                       tx_ready,
    input  usb_packet_pkg::pkt_byte_t  rx_data,
    input  logic                       rx_valid,
    output logic                       rx_ready,
    output logic                       dev_ready
);

    logic drop;

    bag_if cs_send ();
    bag_if cs_read ();
    bag_if usb_send ();
    bag_if usb_read ();

    console_regs #(
        .DROP_CNT_W(DROP_CNT_W)
    ) console_regs_inst (
        .clk       (clk),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pslverr   (pslverr),
        .cs_send   (cs_send),
        .cs_read   (cs_read),
        .dev_ready (dev_ready),
        .drop      (drop)
    );

    usb_branch usb_branch_inst (
        .clk       (clk),
        .rst       (rst),
        .cs_send   (cs_send),
        .cs_read   (cs_read),
        .usb_send  (usb_send),
        .usb_read  (usb_read),
        .dev_ready (dev_ready),
        .drop      (drop)
    );

    usb_pkt_tx usb_pkt_tx_inst (
        .clk      (clk),
        .rst      (rst),
        .usb_send (usb_send),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready)
    );

    usb_pkt_rx usb_pkt_rx_inst (
        .clk      (clk),
        .rst      (rst),
        .usb_read (usb_read),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready)
    );

endmodule

// File: tb_clock_gen.sv
module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset is released on a falling edge, away from the flops' active edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
    end

endmodule

// File: tb_usb_console_bridge.sv
module tb_usb_console_bridge;
    timeunit 1ns;
    timeprecision 1ps;
    import usb_packet_pkg::*;
    import bridge_regs_pkg::*;

    localparam int TIMEOUT_CYCLES = 400;
    localparam int TIMEOUT_POLLS  = 100;

    logic      clk;
    logic      rst;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pslverr;
    pkt_byte_t tx_data;
    logic      tx_valid;
    logic      tx_ready;
    pkt_byte_t rx_data;
    logic      rx_valid;
    logic      rx_ready;
    logic      dev_ready;

    integer      seed = 32'h833a_9899;
    int          errors = 0;
    int          test_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    logic        timed_out = 1'b0;
    logic [39:0] expect_q [$];
    logic [39:0] capture_q [$];

    tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(4)) clock_gen_inst (.clk(clk), .rst(rst));

    usb_console_bridge usb_console_bridge_inst (
        .clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pslverr(pslverr),
        .tx_data(tx_data), .tx_valid(tx_valid), .tx_ready(tx_ready),
        .rx_data(rx_data), .rx_valid(rx_valid), .rx_ready(rx_ready),
        .dev_ready(dev_ready)
    );

    // The type byte with a zero high nibble goes first and the word follows MSB first
    function automatic logic [39:0] expected_packet(input bag_type_t t, input dev_idx_t dev,
                                                    input data_idx_t didx, input conf_cmd_t conf);
        pkt_word_t w;
        case (t)
            BAG_DPARAM: w = {dev, 4'h0, conf, 8'h00};
            BAG_DIDX:   w = {dev, didx, conf, 8'h00};
            default:    w = {dev, 28'h0};
        endcase
        return {4'h0, t, w};
    endfunction

    task automatic check_value(input string name, input logic [39:0] got, input logic [39:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        if (!timed_out) begin
            $display("timeout at %0t: %s did not happen in time", $time, what);
        end
        timed_out = 1'b1;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
        @(negedge clk);
        psel = 1'b1;
        pwrite = 1'b1;
        penable = 1'b0;
        paddr = addr;
        pwdata = data;
        @(negedge clk);
        penable = 1'b1;
        #1;
        err = pslverr;
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
        @(negedge clk);
        psel = 1'b1;
        pwrite = 1'b0;
        penable = 1'b0;
        paddr = addr;
        @(negedge clk);
        penable = 1'b1;
        #1;
        data = prdata;
        err = pslverr;
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
    endtask

    // Polls STATUS until the masked bits reach the wanted value
    task automatic wait_status(input apb_data_t mask, input apb_data_t value, input string what);
        apb_data_t st;
        logic      err;
        int        polls = 0;
        apb_read(REG_STATUS, st, err);
        while (((st & mask) != value) && polls < TIMEOUT_POLLS) begin
            apb_read(REG_STATUS, st, err);
            polls++;
        end
        if ((st & mask) != value) begin
            report_timeout(what);
        end
    endtask

    task automatic send_packet(input bag_type_t t, input pkt_word_t w);
        logic [39:0] bytes;
        int          cycles;
        bytes = {4'h0, t, w};
        for (int i = 0; i < PKT_BYTES; i++) begin
            cycles = 0;
            @(negedge clk);
            rx_valid = 1'b1;
            rx_data = bytes[39 - 8 * i -: 8];
            while (!rx_ready && cycles < TIMEOUT_CYCLES) begin
                @(negedge clk);
                cycles++;
            end
            if (!rx_ready) begin
                report_timeout("rx_ready for a device packet byte");
                break;
            end
        end
        @(negedge clk);
        rx_valid = 1'b0;
    endtask

    task automatic capture_packet();
        logic [39:0] pkt = '0;
        logic [31:0] rnd;
        int          count = 0;
        int          cycles = 0;
        while (count < PKT_BYTES && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            rnd = $random(seed);
            tx_ready = rnd[0];
            if (tx_valid && tx_ready) begin
                pkt = {pkt[31:0], tx_data};
                count++;
            end
            cycles++;
        end
        @(negedge clk);
        tx_ready = 1'b0;
        if (count < PKT_BYTES) begin
            report_timeout("tx packet from the bridge");
        end else begin
            capture_q.push_back(pkt);
        end
    endtask

    task automatic drain_compare();
        int cycles = 0;
        while (capture_q.size() > 0 && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (capture_q.size() > 0) begin
            report_timeout("tx packet comparison");
        end
    endtask

    always @(negedge clk) begin
        if (capture_q.size() > 0 && expect_q.size() > 0) begin
            check_value("tx packet", capture_q.pop_front(), expect_q.pop_front());
        end
    end

    initial begin
        wait (timed_out);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        logic [31:0] rnd;
        apb_data_t   st;
        logic        err;
        dev_idx_t    dev;
        data_idx_t   didx;
        conf_cmd_t   conf;
        logic [7:0]  drop0;
        pkt_word_t   w1;
        pkt_word_t   w2;
        bag_type_t   up_types [3];
        int          cycles;
        logic        seen_valid;

        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        tx_ready = 1'b0;
        rx_data = '0;
        rx_valid = 1'b0;
        up_types = '{BAG_DTEMP, BAG_DATA0, BAG_DATA1};
        $timeformat(-9, 0, " ns", 0);

        cycles = 0;
        while ((rst !== 1'b0) && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (rst !== 1'b0) begin
            report_timeout("reset release");
        end

        // DLINK is answered with DDIDX carrying the reset device index
        check_value("tx_valid", tx_valid, 1'b0);
        check_value("dev_ready", dev_ready, 1'b0);
        check_value("rx_ready", rx_ready, 1'b1);
        apb_read(REG_STATUS, st, err);
        check_value("status", st, 32'h0);
        expect_q.push_back(expected_packet(BAG_DDIDX, 4'h0, 4'h0, 16'h0));
        rnd = $random(seed);
        send_packet(BAG_DLINK, rnd);
        capture_packet();
        drain_compare();
        rnd = $random(seed);
        send_packet(BAG_DTYPE, rnd);
        cycles = 0;
        while (!dev_ready && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (!dev_ready) begin
            report_timeout("dev_ready after DTYPE");
        end
        apb_read(REG_STATUS, st, err);
        check_value("status", st, 32'h1);
        finish_test("bring_up");

        rnd = $random(seed);
        dev = rnd[3:0];
        didx = rnd[7:4];
        conf = rnd[31:16];
        apb_write(REG_CFG, {24'h0, didx, dev}, err);
        check_value("pslverr", err, 1'b0);
        apb_write(REG_CONF, {16'h0, conf}, err);
        check_value("pslverr", err, 1'b0);
        expect_q.push_back(expected_packet(BAG_DPARAM, dev, didx, conf));
        apb_write(REG_CTRL, {28'h0, BAG_DPARAM}, err);
        check_value("pslverr", err, 1'b0);
        capture_packet();
        drain_compare();
        wait_status(32'h2, 32'h0, "send busy clear after DPARAM");
        finish_test("parameter_command");

        // tx_ready stays low until capture, so the send is still busy at the second write
        rnd = $random(seed);
        dev = rnd[3:0];
        didx = rnd[7:4];
        conf = rnd[31:16];
        apb_write(REG_CFG, {24'h0, didx, dev}, err);
        apb_write(REG_CONF, {16'h0, conf}, err);
        expect_q.push_back(expected_packet(BAG_DIDX, dev, didx, conf));
        apb_write(REG_CTRL, {28'h0, BAG_DIDX}, err);
        check_value("pslverr", err, 1'b0);
        apb_write(REG_CTRL, {28'h0, BAG_DIDX}, err);
        check_value("pslverr", err, 1'b1);
        capture_packet();
        drain_compare();
        wait_status(32'h2, 32'h0, "send busy clear after DIDX");
        finish_test("conversion_request");

        for (int i = 0; i < 3; i++) begin
            w1 = $random(seed);
            send_packet(up_types[i], w1);
            wait_status(32'h4, 32'h4, "read pending");
            apb_read(REG_STATUS, st, err);
            check_value("status.type", st[11:8], up_types[i]);
            apb_read(REG_RDATA, st, err);
            check_value("rdata", st, w1);
            apb_read(REG_STATUS, st, err);
            check_value("status.pending", st[2], 1'b0);
        end
        w1 = $random(seed);
        w2 = $random(seed);
        send_packet(BAG_DATA0, w1);
        wait_status(32'h4, 32'h4, "first read pending");
        check_value("rx_ready", rx_ready, 1'b0);
        fork
            send_packet(BAG_DATA1, w2);
            begin
                apb_read(REG_STATUS, st, err);
                check_value("status.type", st[11:8], BAG_DATA0);
                apb_read(REG_RDATA, st, err);
                check_value("rdata", st, w1);
            end
        join
        wait_status(32'h4, 32'h4, "second read pending");
        apb_read(REG_STATUS, st, err);
        check_value("status.type", st[11:8], BAG_DATA1);
        apb_read(REG_RDATA, st, err);
        check_value("rdata", st, w2);
        finish_test("upstream_reads");

        apb_read(REG_STATUS, st, err);
        drop0 = st[23:16];
        rnd = $random(seed);
        send_packet(BAG_ACK, rnd);
        wait_status(32'h00FF_0000, {8'h00, drop0 + 8'd1, 16'h0000}, "drop count increment");
        apb_read(REG_STATUS, st, err);
        check_value("status.pending", st[2], 1'b0);
        apb_write(REG_CTRL, {28'h0, BAG_ACK}, err);
        check_value("pslverr", err, 1'b0);
        wait_status(32'h2, 32'h0, "send busy clear after ACK");
        seen_valid = 1'b0;
        repeat (50) begin
            @(negedge clk);
            seen_valid = seen_valid | tx_valid;
        end
        check_value("tx_valid", seen_valid, 1'b0);
        apb_read(8'h20, st, err);
        check_value("pslverr", err, 1'b1);
        apb_write(8'h14, 32'h0, err);
        check_value("pslverr", err, 1'b1);
        finish_test("drops_and_errors");

        $display("tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && !timed_out) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: usb_console_bridge.f
usb_packet_pkg.sv
bridge_regs_pkg.sv
bag_if.sv
console_regs.sv
usb_branch.sv
usb_pkt_tx.sv
usb_pkt_rx.sv
usb_console_bridge.sv
tb_clock_gen.sv
tb_usb_console_bridge.sv

// File: Makefile
TOP = tb_usb_console_bridge

.PHONY: all lint clean

all:
	verilator --binary --timing -Wno-fatal -f usb_console_bridge.f --top-module $(TOP)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

lint:
	verilator --lint-only --timing -f usb_console_bridge.f --top-module usb_console_bridge

clean:
	rm -rf obj_dir
